// File: logic/rv_pkg.sv
package rv_pkg;

  // rv32i major opcodes
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // values match funct3 of the branch instructions
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cond_e;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

  typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP} pc_sel_e;

  typedef struct packed {
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic       rf_wen;
    logic       mem_wen;
    logic       mem_ren;
    logic [2:0] mem_fn3;
    logic       op1_pc;
    logic       op2_imm;
    alu_op_e    alu_op;
    br_cond_e   br_cond;
    wb_sel_e    wb_sel;
    pc_sel_e    pc_sel;
    logic       is_halt;
  } ctrl_t;

  typedef enum logic [1:0] {FETCH, OPERAND, EXECUTE, WRITEBACK} phase_e;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [2:0]  fn3;
    logic        wen;
    logic        ren;
  } dmem_req_t;

endpackage

// File: logic/control_unit.sv
`timescale 1ns/100ps

module control_unit import rv_pkg::*; (
  input  logic [31:0] instr,
  output ctrl_t       ctrl
);

  // funct3/funct7 to alu op, sub only exists for register form
  function automatic alu_op_e alu_decode(input logic [2:0] fn3, input logic alt,
                                         input logic is_reg);
    alu_op_e op;
    case (fn3)
      3'b000:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    ctrl         = '0;
    ctrl.rs1     = instr[19:15];
    ctrl.rs2     = instr[24:20];
    ctrl.rd      = instr[11:7];
    ctrl.mem_fn3 = instr[14:12];
    ctrl.alu_op  = ALU_ADD;
    ctrl.br_cond = BR_EQ;
    ctrl.wb_sel  = WB_ALU;
    ctrl.pc_sel  = PC_SEQ;

    case (instr[6:0])
      OP: begin
        ctrl.rf_wen = 1'b1;
        ctrl.alu_op = alu_decode(instr[14:12], instr[30], 1'b1);
      end
      OP_IMM: begin
        ctrl.rf_wen  = 1'b1;
        ctrl.op2_imm = 1'b1;
        ctrl.alu_op  = alu_decode(instr[14:12], instr[30], 1'b0);
      end
      LOAD: begin
        ctrl.rf_wen  = 1'b1;
        ctrl.mem_ren = 1'b1;
        ctrl.op2_imm = 1'b1;
        ctrl.wb_sel  = WB_MEM;
      end
      STORE: begin
        ctrl.mem_wen = 1'b1;
        ctrl.op2_imm = 1'b1;
      end
      BRANCH: begin
        // alu forms the target, comparator decides
        ctrl.op1_pc  = 1'b1;
        ctrl.op2_imm = 1'b1;
        ctrl.pc_sel  = PC_BRANCH;
        ctrl.br_cond = br_cond_e'(instr[14:12]);
      end
      JAL: begin
        ctrl.rf_wen  = 1'b1;
        ctrl.op1_pc  = 1'b1;
        ctrl.op2_imm = 1'b1;
        ctrl.wb_sel  = WB_PC4;
        ctrl.pc_sel  = PC_JUMP;
      end
      JALR: begin
        ctrl.rf_wen  = 1'b1;
        ctrl.op2_imm = 1'b1;
        ctrl.wb_sel  = WB_PC4;
        ctrl.pc_sel  = PC_JUMP;
      end
      LUI: begin
        ctrl.rf_wen  = 1'b1;
        ctrl.op2_imm = 1'b1;
        ctrl.alu_op  = ALU_PASS_B;
      end
      AUIPC: begin
        ctrl.rf_wen  = 1'b1;
        ctrl.op1_pc  = 1'b1;
        ctrl.op2_imm = 1'b1;
      end
      SYSTEM:  ctrl.is_halt = 1'b1;
      default: ctrl.rf_wen = 1'b0;
    endcase
  end

endmodule

// File: logic/imm_gen.sv
`timescale 1ns/100ps

module imm_gen import rv_pkg::*; (
  input  logic [31:0] instr,
  output logic [31:0] imm
);

  always_comb begin
    case (instr[6:0])
      OP_IMM, LOAD, JALR: begin
        imm = {{20{instr[31]}}, instr[31:20]};
      end
      STORE: begin
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      BRANCH: begin
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      // upper immediate, low bits zero
      LUI, AUIPC: begin
        imm = {instr[31:12], 12'b0};
      end
      JAL: begin
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: imm = '0;
    endcase
  end

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/100ps

module exec_unit import rv_pkg::*; (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  alu_op_e     alu_op,
  input  br_cond_e    br_cond,
  input  logic [31:0] rs1_val,
  input  logic [31:0] rs2_val,
  output logic [31:0] result,
  output logic        taken
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU:   result = {31'b0, a < b};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = a + b;
    endcase
  end

  // comparator works on the register values, not the alu operands
  always_comb begin
    case (br_cond)
      BR_EQ:   taken = (rs1_val == rs2_val);
      BR_NE:   taken = (rs1_val != rs2_val);
      BR_LT:   taken = ($signed(rs1_val) < $signed(rs2_val));
      BR_GE:   taken = ($signed(rs1_val) >= $signed(rs2_val));
      BR_LTU:  taken = (rs1_val < rs2_val);
      BR_GEU:  taken = (rs1_val >= rs2_val);
      default: taken = 1'b0;
    endcase
  end

endmodule

// File: logic/register_file.sv
`timescale 1ns/100ps

module register_file (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        wen,
  input  logic [31:0] wdata,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2,
  output logic [31:0] gp
);

  // x0 has no storage
  logic [31:0] regs [1:31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

  // x3 for observation
  assign gp = regs[3];

endmodule

// File: logic/instr_mem.sv
`timescale 1ns/100ps

module instr_mem #(
  parameter int IMEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic [31:0]                   addr,
  output logic [31:0]                   rdata,
  input  logic                          prog_we,
  input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr,
  input  logic [31:0]                   prog_wdata
);

  localparam int AW = $clog2(IMEM_WORDS);

  logic [31:0] mem [IMEM_WORDS];

  // only word bits index the array, base address drops out
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_wdata;
    end
    rdata <= mem[addr[AW+1:2]];
  end

endmodule

// File: logic/data_mem.sv
`timescale 1ns/100ps

module data_mem import rv_pkg::*; #(
  parameter int DMEM_WORDS = 256
) (
  input  logic        clk,
  input  dmem_req_t   req,
  output logic [31:0] rdata
);

  localparam int AW = $clog2(DMEM_WORDS);

  logic [31:0]   mem [DMEM_WORDS];
  logic [AW-1:0] widx;
  logic [3:0]    be;
  logic [31:0]   wlane;
  logic [31:0]   word_q;
  logic [1:0]    off_q;
  logic [2:0]    fn3_q;
  logic [7:0]    byte_sel;
  logic [15:0]   half_sel;

  assign widx = req.addr[AW+1:2];

  // lane enables and replicated store data
  always_comb begin
    case (req.fn3[1:0])
      2'b00: begin
        be    = 4'b0001 << req.addr[1:0];
        wlane = {4{req.wdata[7:0]}};
      end
      2'b01: begin
        be    = req.addr[1] ? 4'b1100 : 4'b0011;
        wlane = {2{req.wdata[15:0]}};
      end
      default: begin
        be    = 4'b1111;
        wlane = req.wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (req.wen) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          mem[widx][8*i +: 8] <= wlane[8*i +: 8];
        end
      end
    end
    if (req.ren) begin
      word_q <= mem[widx];
      off_q  <= req.addr[1:0];
      fn3_q  <= req.fn3;
    end
  end

  assign byte_sel = word_q[8*off_q +: 8];
  assign half_sel = off_q[1] ? word_q[31:16] : word_q[15:0];

  // extension after the registered read
  always_comb begin
    case (fn3_q)
      3'b000:  rdata = {{24{byte_sel[7]}}, byte_sel};
      3'b001:  rdata = {{16{half_sel[15]}}, half_sel};
      3'b100:  rdata = {24'b0, byte_sel};
      3'b101:  rdata = {16'b0, half_sel};
      default: rdata = word_q;
    endcase
  end

endmodule

// File: logic/rv_core.sv
`timescale 1ns/100ps

module rv_core import rv_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        run,
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_rdata,
  output dmem_req_t   dmem_req,
  input  logic [31:0] dmem_rdata,
  output logic        halted,
  output logic [31:0] retired,
  output logic [31:0] gp
);

  phase_e      phase;
  logic        advance;
  logic [31:0] pc;
  logic [31:0] pc_plus4;
  logic [31:0] next_pc;
  ctrl_t       ctrl;
  ctrl_t       ctrl_q;
  logic [31:0] imm;
  logic [31:0] imm_q;
  logic [31:0] rdata1;
  logic [31:0] rdata2;
  logic [31:0] rs1_q;
  logic [31:0] rs2_q;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic [31:0] alu_q;
  logic        taken;
  logic        taken_q;
  logic [31:0] wb_data;
  logic        rf_wen;

  assign advance = run && !halted;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase <= FETCH;
    end else if (advance) begin
      phase <= phase_e'(phase + 2'd1);
    end
  end

  // fetched word is valid during OPERAND, decode straight from it
  control_unit i_control_unit (
    .instr (imem_rdata),
    .ctrl  (ctrl)
  );

  imm_gen i_imm_gen (
    .instr (imem_rdata),
    .imm   (imm)
  );

  assign rf_wen = advance && phase == WRITEBACK && ctrl_q.rf_wen;

  register_file i_register_file (
    .clk    (clk),
    .arst_n (arst_n),
    .rs1    (ctrl.rs1),
    .rs2    (ctrl.rs2),
    .rd     (ctrl_q.rd),
    .wen    (rf_wen),
    .wdata  (wb_data),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .gp     (gp)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q <= '0;
    end else if (advance && phase == OPERAND) begin
      ctrl_q <= ctrl;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && phase == OPERAND) begin
      imm_q <= imm;
      rs1_q <= rdata1;
      rs2_q <= rdata2;
    end
    if (advance && phase == EXECUTE) begin
      alu_q   <= alu_result;
      taken_q <= taken;
    end
  end

  assign alu_a = ctrl_q.op1_pc ? pc : rs1_q;
  assign alu_b = ctrl_q.op2_imm ? imm_q : rs2_q;

  exec_unit i_exec_unit (
    .a       (alu_a),
    .b       (alu_b),
    .alu_op  (ctrl_q.alu_op),
    .br_cond (ctrl_q.br_cond),
    .rs1_val (rs1_q),
    .rs2_val (rs2_q),
    .result  (alu_result),
    .taken   (taken)
  );

  // address straight from the alu so data comes back in WRITEBACK
  assign dmem_req.addr  = alu_result;
  assign dmem_req.wdata = rs2_q;
  assign dmem_req.fn3   = ctrl_q.mem_fn3;
  assign dmem_req.wen   = advance && phase == EXECUTE && ctrl_q.mem_wen;
  assign dmem_req.ren   = advance && phase == EXECUTE && ctrl_q.mem_ren;

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (ctrl_q.wb_sel)
      WB_MEM:  wb_data = dmem_rdata;
      WB_PC4:  wb_data = pc_plus4;
      default: wb_data = alu_q;
    endcase
  end

  // jump targets lose bit 0 (jalr rule, harmless for jal)
  always_comb begin
    case (ctrl_q.pc_sel)
      PC_JUMP:   next_pc = {alu_q[31:1], 1'b0};
      PC_BRANCH: next_pc = taken_q ? alu_q : pc_plus4;
      default:   next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc      <= RESET_PC;
      halted  <= 1'b0;
      retired <= '0;
    end else if (advance && phase == WRITEBACK) begin
      if (ctrl_q.is_halt) begin
        halted <= 1'b1;
      end else begin
        pc      <= next_pc;
        retired <= retired + 32'd1;
      end
    end
  end

  assign imem_addr = pc;

endmodule

// File: logic/rv_soc.sv
`timescale 1ns/100ps

module rv_soc import rv_pkg::*; #(
  parameter logic [31:0] RESET_PC   = 32'h8000_0000,
  parameter int          IMEM_WORDS = 256,
  parameter int          DMEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          run,
  input  logic                          prog_we,
  input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr,
  input  logic [31:0]                   prog_wdata,
  output logic                          halted,
  output logic [31:0]                   retired,
  output logic [31:0]                   gp
);

  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  dmem_req_t   dmem_req;
  logic [31:0] dmem_rdata;

  rv_core #(
    .RESET_PC (RESET_PC)
  ) i_rv_core (
    .clk        (clk),
    .arst_n     (arst_n),
    .run        (run),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .halted     (halted),
    .retired    (retired),
    .gp         (gp)
  );

  instr_mem #(
    .IMEM_WORDS (IMEM_WORDS)
  ) i_instr_mem (
    .clk        (clk),
    .addr       (imem_addr),
    .rdata      (imem_rdata),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_wdata (prog_wdata)
  );

  data_mem #(
    .DMEM_WORDS (DMEM_WORDS)
  ) i_data_mem (
    .clk   (clk),
    .req   (dmem_req),
    .rdata (dmem_rdata)
  );

endmodule

// File: tests/rv_soc_chk.sv
`timescale 1ns/100ps

module rv_soc_chk import rv_pkg::*; (
  input logic        clk,
  input logic        arst_n,
  input logic        advance,
  input phase_e      phase,
  input logic        halted,
  input logic [31:0] retired,
  input ctrl_t       ctrl,
  input logic [31:0] rs1_q,
  input logic [31:0] rs2_q
);

  // one phase step per enabled cycle with a wrap after WRITEBACK
  assert property (@(posedge clk) disable iff (!arst_n)
    advance |=> phase == phase_e'($past(phase) + 2'd1))
    else $error("phase did not step while running");

  assert property (@(posedge clk) disable iff (!arst_n)
    phase != WRITEBACK |=> $stable(retired))
    else $error("retired changed outside write-back");

  assert property (@(posedge clk) disable iff (!arst_n)
    halted |=> halted)
    else $error("halted dropped without reset");

  // x0 operands reach execute as zero even after writes to x0
  assert property (@(posedge clk) disable iff (!arst_n)
    advance && phase == OPERAND && ctrl.rs1 == 5'd0 |=> rs1_q == 32'd0)
    else $error("x0 latched a non-zero rs1 operand");

  assert property (@(posedge clk) disable iff (!arst_n)
    advance && phase == OPERAND && ctrl.rs2 == 5'd0 |=> rs2_q == 32'd0)
    else $error("x0 latched a non-zero rs2 operand");

endmodule

bind rv_core rv_soc_chk i_rv_soc_chk (
  .clk     (clk),
  .arst_n  (arst_n),
  .advance (advance),
  .phase   (phase),
  .halted  (halted),
  .retired (retired),
  .ctrl    (ctrl),
  .rs1_q   (rs1_q),
  .rs2_q   (rs2_q)
);

// File: tests/rv_soc_tb.sv
`timescale 1ns/100ps

module rv_soc_tb;

  localparam logic [31:0] RESET_PC = 32'h8000_0000;
  localparam int RESET_CYCLES = 16;
  // program words per test are 43 + 27 + 59 + 10 + 7
  localparam int TOTAL_INSTR = 146;
  localparam int CYCLE_LIMIT = 4 * TOTAL_INSTR * 2 + RESET_CYCLES * 6;
  localparam logic [6:0] OPC_REG = 7'h33;
  localparam logic [6:0] OPC_IMM = 7'h13;
  localparam logic [6:0] OPC_LOAD = 7'h03;
  localparam logic [6:0] OPC_AUIPC = 7'h17;
  localparam logic [6:0] OPC_JALR = 7'h67;
  localparam logic [31:0] ECALL = 32'h0000_0073;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        run;
  logic        prog_we;
  logic [7:0]  prog_addr;
  logic [31:0] prog_wdata;
  logic        halted;
  logic [31:0] retired;
  logic [31:0] gp;
  logic [31:0] prog [$];
  // bytes 0x40 to 0x4f of data memory
  logic [7:0]  mem_model [16];
  int          cycles = 0;
  bit          reported = 1'b0;

  rv_soc #(
    .RESET_PC   (RESET_PC),
    .IMEM_WORDS (256),
    .DMEM_WORDS (256)
  ) i_rv_soc (
    .clk        (clk),
    .arst_n     (arst_n),
    .run        (run),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_wdata (prog_wdata),
    .halted     (halted),
    .retired    (retired),
    .gp         (gp)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      reported = 1'b1;
      $display("timeout: core did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Verification failed");
      $fatal(1, "simulation timed out");
    end
  end

  // instruction formats
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_REG};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[4:0];
      3'd2:    return {31'b0, $signed(x) < $signed(y)};
      3'd3:    return {31'b0, x < y};
      3'd4:    return x ^ y;
      3'd5:    return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic [31:0] read_model(input int off, input logic [2:0] f3);
    logic [7:0]  lo_byte;
    logic [15:0] lo_half;
    lo_byte = mem_model[off];
    lo_half = {mem_model[off + 1], mem_model[off]};
    case (f3)
      3'b000:  return {{24{lo_byte[7]}}, lo_byte};
      3'b001:  return {{16{lo_half[15]}}, lo_half};
      3'b100:  return {24'b0, lo_byte};
      3'b101:  return {16'b0, lo_half};
      default: return {mem_model[off + 3], mem_model[off + 2], lo_half};
    endcase
  endfunction

  function automatic bit branch_model(input logic [2:0] f3, input logic [31:0] x,
                                      input logic [31:0] y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      3'b111:  return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  task automatic write_model(input int off, input logic [31:0] data, input int nbytes);
    for (int k = 0; k < nbytes; k++) begin
      mem_model[off + k] = data[8*k +: 8];
    end
  endtask

  // lui plus addi with the upper part rounded for the signed low part
  task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value - {{20{value[11]}}, value[11:0]};
    prog.push_back(u_type(upper[31:12], rd, 7'h37));
    prog.push_back(i_type(value[11:0], rd, 3'd0, rd, OPC_IMM));
  endtask

  task automatic accumulate_gp(input logic [4:0] rs);
    prog.push_back(r_type(7'h00, rs, 5'd3, 3'd0, 5'd3));
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      reported = 1'b1;
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic reset_dut();
    @(negedge clk);
    arst_n  = 1'b0;
    run     = 1'b0;
    prog_we = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    prog.delete();
  endtask

  task automatic load_program();
    foreach (prog[i]) begin
      @(negedge clk);
      prog_we    = 1'b1;
      prog_addr  = 8'(i);
      prog_wdata = prog[i];
    end
    @(negedge clk);
    prog_we = 1'b0;
  endtask

  task automatic run_until_halt();
    @(negedge clk);
    run = 1'b1;
    while (!halted) @(negedge clk);
  endtask

  task automatic idle_before_run();
    reset_dut();
    repeat (10) @(negedge clk);
    check("idle halted", 32'd0, {31'b0, halted});
    check("idle retired", 32'd0, retired);
  endtask

  task automatic arith_logic();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] y;
    logic [31:0] sum;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic        alt;
    reset_dut();
    a   = $urandom();
    b   = $urandom();
    sum = '0;
    set_reg(5'd1, a);
    set_reg(5'd2, b);
    // register forms with sub and sra last
    for (int i = 0; i < 10; i++) begin
      f3  = (i < 8) ? 3'(i) : ((i == 8) ? 3'd0 : 3'd5);
      alt = (i >= 8);
      prog.push_back(r_type(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd4));
      accumulate_gp(5'd4);
      sum += alu_model(f3, alt, a, b);
    end
    // immediate forms with srai last
    for (int i = 0; i < 9; i++) begin
      f3  = (i < 8) ? 3'(i) : 3'd5;
      alt = (i == 8);
      if (f3 == 3'd1 || f3 == 3'd5) begin
        imm = {1'b0, alt, 5'b0, 5'($urandom())};
        y   = {27'b0, imm[4:0]};
      end else begin
        imm = 12'($urandom());
        y   = {{20{imm[11]}}, imm};
      end
      prog.push_back(i_type(imm, 5'd1, f3, 5'd4, OPC_IMM));
      accumulate_gp(5'd4);
      sum += alu_model(f3, alt, a, y);
    end
    prog.push_back(ECALL);
    load_program();
    run_until_halt();
    check("arith gp", sum, gp);
    check("arith retired", 32'd42, retired);
  endtask

  task automatic memory_access();
    int          offs [7] = '{1, 11, 6, 6, 0, 4, 8};
    logic [2:0]  fns [7] = '{3'b000, 3'b100, 3'b001, 3'b101, 3'b010, 3'b101, 3'b000};
    logic [31:0] w;
    logic [31:0] h;
    logic [31:0] bt;
    logic [31:0] sum;
    reset_dut();
    w   = $urandom();
    h   = $urandom();
    bt  = $urandom();
    sum = '0;
    set_reg(5'd1, w);
    for (int k = 0; k < 3; k++) begin
      prog.push_back(s_type(12'(32'h40 + 4 * k), 5'd1, 5'd0, 3'b010));
      write_model(4 * k, w, 4);
    end
    set_reg(5'd2, h);
    prog.push_back(s_type(12'h046, 5'd2, 5'd0, 3'b001));
    write_model(6, h, 2);
    set_reg(5'd4, bt);
    prog.push_back(s_type(12'h041, 5'd4, 5'd0, 3'b000));
    prog.push_back(s_type(12'h04b, 5'd4, 5'd0, 3'b000));
    write_model(1, bt, 1);
    write_model(11, bt, 1);
    for (int k = 0; k < 7; k++) begin
      prog.push_back(i_type(12'(32'h40 + offs[k]), 5'd0, fns[k], 5'd5, OPC_LOAD));
      accumulate_gp(5'd5);
      sum += read_model(offs[k], fns[k]);
    end
    prog.push_back(ECALL);
    load_program();
    run_until_halt();
    check("memory gp", sum, gp);
    check("memory retired", 32'd26, retired);
  endtask

  task automatic branches();
    logic [2:0]  conds [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sum;
    logic [11:0] k;
    logic [4:0]  r1;
    logic [4:0]  r2;
    int          n;
    reset_dut();
    // opposite signs so signed and unsigned compares disagree
    a   = $urandom() | 32'h8000_0000;
    b   = $urandom() & 32'h7fff_ffff;
    sum = '0;
    n   = 0;
    set_reg(5'd1, a);
    set_reg(5'd2, b);
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        r1 = (p == 1) ? 5'd2 : 5'd1;
        r2 = (p == 0) ? 5'd2 : 5'd1;
        n++;
        k  = 12'(37 * n);
        // taken lands on the addi while not taken jumps over it
        prog.push_back(b_type(13'd8, r2, r1, conds[c]));
        prog.push_back(j_type(21'd8, 5'd0));
        prog.push_back(i_type(k, 5'd3, 3'd0, 5'd3, OPC_IMM));
        if (branch_model(conds[c], (r1 == 5'd1) ? a : b, (r2 == 5'd1) ? a : b)) begin
          sum += {20'b0, k};
        end
      end
    end
    prog.push_back(ECALL);
    load_program();
    run_until_halt();
    check("branch gp", sum, gp);
    check("branch retired", 32'd40, retired);
  endtask

  task automatic jumps();
    logic [31:0] expected;
    reset_dut();
    prog.push_back(j_type(21'd8, 5'd1));
    prog.push_back(i_type(12'd1, 5'd3, 3'd0, 5'd3, OPC_IMM));
    accumulate_gp(5'd1);
    prog.push_back(u_type(20'h00001, 5'd5, OPC_AUIPC));
    accumulate_gp(5'd5);
    prog.push_back(u_type(20'h00000, 5'd6, OPC_AUIPC));
    // odd offset still lands on word 8
    prog.push_back(i_type(12'd13, 5'd6, 3'd0, 5'd7, OPC_JALR));
    prog.push_back(i_type(12'd2, 5'd3, 3'd0, 5'd3, OPC_IMM));
    accumulate_gp(5'd7);
    prog.push_back(ECALL);
    expected = (RESET_PC + 32'd0 + 32'd4) + (RESET_PC + 32'd12 + 32'h1000)
             + (RESET_PC + 32'd24 + 32'd4);
    load_program();
    run_until_halt();
    check("jump gp", expected, gp);
    check("jump retired", 32'd7, retired);
  endtask

  task automatic halt_and_count();
    logic [31:0] v;
    reset_dut();
    v = $urandom();
    set_reg(5'd3, v);
    prog.push_back(i_type(12'd5, 5'd3, 3'd0, 5'd3, OPC_IMM));
    prog.push_back(i_type(12'd7, 5'd0, 3'd0, 5'd4, OPC_IMM));
    accumulate_gp(5'd4);
    prog.push_back(ECALL);
    // must never execute
    prog.push_back(i_type(12'd100, 5'd3, 3'd0, 5'd3, OPC_IMM));
    load_program();
    run_until_halt();
    check("halt gp", v + 32'd12, gp);
    check("halt retired", 32'd5, retired);
    repeat (20) @(negedge clk);
    check("halt flag held", 32'd1, {31'b0, halted});
    check("halt gp held", v + 32'd12, gp);
    check("halt retired held", 32'd5, retired);
  endtask

  initial begin
    arst_n     = 1'b0;
    run        = 1'b0;
    prog_we    = 1'b0;
    prog_addr  = '0;
    prog_wdata = '0;
    void'($urandom(70));
    idle_before_run();
    arith_logic();
    memory_access();
    branches();
    jumps();
    halt_and_count();
    reported = 1'b1;
    $display("Verification passed");
    $finish;
  end

  // run stopped by a failed assertion
  final begin
    if (!reported) begin
      $display("Verification failed");
    end
  end

endmodule

// File: rv_soc.f
logic/rv_pkg.sv
logic/control_unit.sv
logic/imm_gen.sv
logic/exec_unit.sv
logic/register_file.sv
logic/instr_mem.sv
logic/data_mem.sv
logic/rv_core.sv
logic/rv_soc.sv
tests/rv_soc_chk.sv
tests/rv_soc_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= rv_soc_tb
FILELIST  ?= rv_soc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
